//--- bench/ovc_alloc_patterns.txt
// digits: op requester class dest_port vc
// op 1 request, 2 pair member, 3 release vc, 4 starved request freed by releasing vc
10010
11021
12042
13083
30000
30001
30002
30003
11112
12183
10021
13020
30000
30001
41143
30002
30003
20011
23010
21142
22143
30000
30001
30002
30003
F0000

//--- bench/ovc_alloc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module ovc_alloc_tb;

    localparam int N       = `NOC_N_REQ;
    localparam int TIMEOUT = 50;                   // cycles before a wait gives up.
    localparam int BLOCKED = 20;                   // cycles a starved request must stay unacked.

    logic                       clk;
    logic                       arst_n;
    logic [N-1:0]               req;
    noc_pkg::class_t [N-1:0]    class_in;
    noc_pkg::dest_t  [N-1:0]    dest_port;
    logic [N-1:0]               ack;
    noc_pkg::ovc_idx_t [N-1:0]  ovc_idx;
    logic                       release_valid;
    noc_pkg::ovc_idx_t          release_ovc;

    logic [19:0] patterns [0:63];                  // op, requester, class, dest, vc.
    logic [3:0]  model_free;                       // free vcs as the model sees them.
    int          model_ptr;                        // round-robin pointer of the model.
    logic [31:0] rng;

    ovc_alloc_top i_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .class_in      (class_in),
        .dest_port     (dest_port),
        .ack           (ack),
        .ovc_idx       (ovc_idx),
        .release_valid (release_valid),
        .release_ovc   (release_ovc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // 100 ns period.
    end

    ////////////////////////////////////////////////////////////
    // reference model.
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // class 1 keeps to the upper two vcs while class 0 uses all.
    function automatic logic [3:0] class_perm(input logic cls);
        return cls ? 4'b1100 : 4'b1111;
    endfunction

    function automatic logic [1:0] model_pick(input logic cls, input logic [3:0] dst,
                                              input logic [3:0] free);
        logic [3:0] cand;
        logic [3:0] pref;
        logic [3:0] sel;
        logic [1:0] idx;
        logic       hit;
        cand = class_perm(cls) & free;
        pref = cand & ((dst == 4'b0) ? 4'b0001 : dst);   // destination bit i prefers vc i.
        sel  = (pref != 4'b0) ? pref : cand;
        idx  = 2'd0;
        hit  = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (sel[b] && !hit) begin
                idx = 2'(b);                       // first free vc from the bottom.
                hit = 1'b1;
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////
    // drive and check.
    ////////////////////////////////////////////////////////////
    task stop_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task check_pattern(input logic [1:0] model, input logic [3:0] file_vc);
        assert ({2'b00, model} == file_vc) else
            stop_run($sformatf("mismatch pattern_vc: file 0x%h model 0x%h", file_vc, model));
    endtask

    task check_vc(input int r, input logic [1:0] exp);
        assert (ovc_idx[r] == exp) else
            stop_run($sformatf("mismatch ovc_idx[%0d]: got 0x%h expected 0x%h",
                               r, ovc_idx[r], exp));
    endtask

    task wait_ack(input int r, input logic level);
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);                        // outputs settled here.
            if (ack[r] === level) break;
        end
        assert (ack[r] === level) else
            stop_run($sformatf("requester %0d never %s its ack within %0d cycles",
                               r, level ? "raised" : "dropped", TIMEOUT));
    endtask

    task raise_req(input int r, input logic cls, input logic [3:0] dst);
        class_in[r]  <= cls;
        dest_port[r] <= dst;
        req[r]       <= 1'b1;
    endtask

    task release_vc(input logic [1:0] v);
        assert (model_free[v] == 1'b0) else
            stop_run($sformatf("pattern file releases vc %0d while it is free", v));
        @(posedge clk);
        release_valid <= 1'b1;
        release_ovc   <= v;
        @(posedge clk);
        release_valid <= 1'b0;                     // one cycle pulse.
        model_free[v] = 1'b1;
    endtask

    task run_single(input logic [19:0] p);
        logic [1:0] exp;
        exp = model_pick(p[8], p[7:4], model_free);
        check_pattern(exp, p[3:0]);
        @(posedge clk);
        raise_req(p[15:12], p[8], p[7:4]);
        wait_ack(p[15:12], 1'b1);
        check_vc(p[15:12], exp);
        model_free[exp] = 1'b0;
        model_ptr = (int'(p[15:12]) + 1) % N;
        @(posedge clk);
        req[p[15:12]] <= 1'b0;
        wait_ack(p[15:12], 1'b0);                  // four-phase close.
    endtask

    // starved request that a release of the vc in the last column unblocks.
    task run_blocked(input logic [19:0] p);
        logic [1:0] exp;
        assert ((class_perm(p[8]) & model_free) == 4'b0) else
            stop_run("pattern file starves a request that has a free vc");
        @(posedge clk);
        raise_req(p[15:12], p[8], p[7:4]);
        for (int n = 0; n < BLOCKED; n++) begin
            @(negedge clk);
            assert (ack[p[15:12]] == 1'b0) else
                stop_run($sformatf("requester %0d acknowledged with no vc free", p[15:12]));
        end
        release_vc(p[1:0]);
        exp = model_pick(p[8], p[7:4], model_free);
        check_pattern(exp, p[3:0]);                // the released vc is the one granted.
        wait_ack(p[15:12], 1'b1);
        check_vc(p[15:12], exp);
        model_free[exp] = 1'b0;
        model_ptr = (int'(p[15:12]) + 1) % N;
        @(posedge clk);
        req[p[15:12]] <= 1'b0;
        wait_ack(p[15:12], 1'b0);
    endtask

    task run_pair(input logic [19:0] pa, input logic [19:0] pb);
        logic [19:0] p1;
        logic [19:0] p2;
        logic [1:0]  e1;
        logic [1:0]  e2;
        // the requester closer to the pointer wins the first cycle.
        if (((int'(pb[15:12]) - model_ptr + N) % N)
                < ((int'(pa[15:12]) - model_ptr + N) % N)) begin
            p1 = pb;
            p2 = pa;
        end else begin
            p1 = pa;
            p2 = pb;
        end
        e1 = model_pick(p1[8], p1[7:4], model_free);
        check_pattern(e1, p1[3:0]);
        model_free[e1] = 1'b0;
        e2 = model_pick(p2[8], p2[7:4], model_free);   // loser re-picks after the winner.
        check_pattern(e2, p2[3:0]);
        model_free[e2] = 1'b0;
        @(posedge clk);
        raise_req(p1[15:12], p1[8], p1[7:4]);
        raise_req(p2[15:12], p2[8], p2[7:4]);
        wait_ack(p1[15:12], 1'b1);
        wait_ack(p2[15:12], 1'b1);
        check_vc(p1[15:12], e1);
        check_vc(p2[15:12], e2);
        model_ptr = (int'(p2[15:12]) + 1) % N;
        @(posedge clk);
        req[p1[15:12]] <= 1'b0;
        req[p2[15:12]] <= 1'b0;
        wait_ack(p1[15:12], 1'b0);
        wait_ack(p2[15:12], 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence.
    ////////////////////////////////////////////////////////////
    initial begin
        int line_no;
        arst_n        = 1'b0;
        req           = '0;
        class_in      = '0;
        dest_port     = '0;
        release_valid = 1'b0;
        release_ovc   = '0;
        model_free    = 4'b1111;                   // all vcs free after reset.
        model_ptr     = 0;
        rng           = 32'd61285;
        line_no       = 0;
        $readmemh("bench/ovc_alloc_patterns.txt", patterns);
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (ack == '0) else
            stop_run($sformatf("mismatch ack: got 0x%h expected 0x0", ack));
        while (patterns[line_no][19:16] != 4'hF) begin
            case (patterns[line_no][19:16])
                4'h1: run_single(patterns[line_no]);
                4'h2: begin
                    assert (patterns[line_no + 1][19:16] == 4'h2) else
                        stop_run("pattern file holds a pair with one member");
                    run_pair(patterns[line_no], patterns[line_no + 1]);
                    line_no++;
                end
                4'h3: release_vc(patterns[line_no][1:0]);
                4'h4: run_blocked(patterns[line_no]);
                default: stop_run($sformatf("unknown operation on pattern line %0d", line_no));
            endcase
            rng = xorshift(rng);
            repeat (rng[1:0]) @(posedge clk);      // idle gap.
            line_no++;
            assert (line_no < 64) else
                stop_run("pattern file has no end marker");
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/class_ovc_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

// class to permitted output vc lookup.
module class_ovc_table #(
    parameter int C = `NOC_C,                              // number of classes.
    parameter int V = `NOC_V,                              // vcs per port.
    parameter logic [((C == 0) ? V : C * V)-1:0] CLASS_SETTING = '1
) (
    input  wire noc_pkg::class_t    class_in,
    output noc_pkg::ovc_mask_t      candidate_ovcs
);

    generate
        if (C <= 1) begin : g_no_class
            // a single class owns the whole pool.
            assign candidate_ovcs = '1;
        end else begin : g_class
            logic [V-1:0] class_table [C];                  // one permission row per class.

            for (genvar i = 0; i < C; i++) begin : g_row
                assign class_table[i] = CLASS_SETTING[i*V +: V];
            end

            assign candidate_ovcs = class_table[class_in];  // row select.
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// router geometry.
`define NOC_P 5                  // ports per router.
`define NOC_V 4                  // vcs per port.
`define NOC_C 2                  // message classes.

// every port except the output one may request it.
`define NOC_N_REQ (`NOC_P - 1)

// class to vc permission, one V wide slice per class, class 0 in the low slice.
// class 1 may use vc 2 and vc 3 only.
// class 0 may use every vc.
`define NOC_CLASS_SETTING 8'b1100_1111

`endif

//--- rtl/noc_pkg.sv
`default_nettype none

`include "noc_params.svh"

////////////////////////////////////////////////////////////
// shared types of the output vc allocator.
////////////////////////////////////////////////////////////
package noc_pkg;

    // one bit per output vc.
    typedef logic [`NOC_V-1:0] ovc_mask_t;

    // index of one output vc.
    typedef logic [$clog2(`NOC_V)-1:0] ovc_idx_t;

    // message class carried by a head flit.
    typedef logic [(`NOC_C > 1 ? $clog2(`NOC_C) : 1)-1:0] class_t;

    // one-hot destination among the other router ports.
    typedef logic [`NOC_P-2:0] dest_t;

endpackage

`default_nettype wire

//--- rtl/ovc_alloc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

// output vc allocator of one router output port.
module ovc_alloc_top (
    input  wire                                     clk,
    input  wire                                     arst_n,
    input  wire  [`NOC_N_REQ-1:0]                   req,
    input  wire noc_pkg::class_t [`NOC_N_REQ-1:0]   class_in,
    input  wire noc_pkg::dest_t  [`NOC_N_REQ-1:0]   dest_port,
    output logic [`NOC_N_REQ-1:0]                   ack,
    output noc_pkg::ovc_idx_t [`NOC_N_REQ-1:0]      ovc_idx,
    input  wire                                     release_valid,
    input  wire noc_pkg::ovc_idx_t                  release_ovc
);

    localparam int N = `NOC_N_REQ;

    logic [N-1:0]                  arb_req;
    logic [N-1:0]                  grant;
    noc_pkg::ovc_idx_t [N-1:0]     pick_idx;       // per-port choice.
    noc_pkg::ovc_mask_t            free_mask;
    logic                          alloc_valid;
    noc_pkg::ovc_idx_t             alloc_idx;

    ////////////////////////////////////////////////////////////
    // requesters.
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < N; i++) begin : g_port
        ovc_request_port i_port (
            .clk       (clk),
            .arst_n    (arst_n),
            .req       (req[i]),
            .class_in  (class_in[i]),
            .dest_port (dest_port[i]),
            .free_mask (free_mask),
            .grant     (grant[i]),
            .ack       (ack[i]),
            .ovc_idx   (ovc_idx[i]),
            .arb_req   (arb_req[i]),
            .pick_idx  (pick_idx[i])
        );
    end

    ovc_rr_arbiter #(
        .N (N)
    ) i_arb (
        .clk     (clk),
        .arst_n  (arst_n),
        .request (arb_req),
        .grant   (grant)
    );

    // grant is one-hot, an or of the masked picks selects the winner.
    always_comb begin
        alloc_idx = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) alloc_idx = alloc_idx | pick_idx[i];
        end
    end

    assign alloc_valid = |grant;                   // at most one vc per cycle.

    ovc_status_table i_status (
        .clk           (clk),
        .arst_n        (arst_n),
        .alloc_valid   (alloc_valid),
        .alloc_idx     (alloc_idx),
        .release_valid (release_valid),
        .release_ovc   (release_ovc),
        .free_mask     (free_mask)
    );

endmodule

`default_nettype wire

//--- rtl/ovc_request_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

// per-requester front end, four-phase req/ack toward the input port.
module ovc_request_port (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      req,          // held high until ack.
    input  wire noc_pkg::class_t     class_in,
    input  wire noc_pkg::dest_t      dest_port,
    input  wire noc_pkg::ovc_mask_t  free_mask,    // from the status table.
    input  wire                      grant,        // this port won the arbiter.
    output logic                     ack,
    output noc_pkg::ovc_idx_t        ovc_idx,      // valid while ack is high.
    output logic                     arb_req,
    output noc_pkg::ovc_idx_t        pick_idx      // vc this port would take now.
);

    noc_pkg::ovc_mask_t cls_mask;                  // vcs the class may use.
    noc_pkg::ovc_mask_t prio_mask;                 // vcs preferred by the destination.
    noc_pkg::ovc_mask_t candidate;                 // permitted and free.
    noc_pkg::ovc_mask_t pref;                      // permitted, free and preferred.
    noc_pkg::ovc_mask_t sel_mask;

    // lowest set bit of a vc mask.
    function automatic noc_pkg::ovc_idx_t lowest_idx(input noc_pkg::ovc_mask_t mask);
        noc_pkg::ovc_idx_t idx;
        idx = '0;
        for (int b = `NOC_V - 1; b >= 0; b--) begin
            if (mask[b]) idx = noc_pkg::ovc_idx_t'(b);
        end
        return idx;
    endfunction

    class_ovc_table #(
        .C             (`NOC_C),
        .V             (`NOC_V),
        .CLASS_SETTING (`NOC_CLASS_SETTING)
    ) i_class_table (
        .class_in       (class_in),
        .candidate_ovcs (cls_mask)
    );

    vc_priority_based_dest_port #(
        .P (`NOC_P),
        .V (`NOC_V)
    ) i_dest_prio (
        .dest_port  (dest_port),
        .vc_pririty (prio_mask)
    );

    ////////////////////////////////////////////////////////////
    // vc selection.
    ////////////////////////////////////////////////////////////
    assign candidate = cls_mask & free_mask;
    assign pref      = candidate & prio_mask;
    assign sel_mask  = (pref != '0) ? pref : candidate;   // preferred first.
    assign pick_idx  = lowest_idx(sel_mask);

    // ask only while waiting and something is available.
    assign arb_req = req & ~ack & (candidate != '0);

    ////////////////////////////////////////////////////////////
    // handshake.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else if (grant) begin
            ack <= 1'b1;                           // vc taken this edge.
        end else if (!req) begin
            ack <= 1'b0;                           // requester released its side.
        end
    end

    always_ff @(posedge clk) begin
        if (grant) ovc_idx <= pick_idx;            // latch the won vc.
    end

endmodule

`default_nettype wire

//--- rtl/ovc_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter, combinational grant, pointer after the winner.
module ovc_rr_arbiter #(
    parameter int N = 4                            // requesters.
) (
    input  wire           clk,
    input  wire           arst_n,
    input  wire  [N-1:0]  request,
    output logic [N-1:0]  grant                    // one-hot or zero.
);

    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [PW-1:0] ptr;                            // highest priority requester.
    logic [PW-1:0] winner;
    logic          found;
    int            scan;

    // search from the pointer upward, wrapping at N.
    always_comb begin
        grant  = '0;
        winner = ptr;
        found  = 1'b0;
        scan   = 0;
        for (int k = 0; k < N; k++) begin
            scan = (int'(ptr) + k) % N;
            if (!found && request[scan]) begin
                found       = 1'b1;
                winner      = PW'(scan);
                grant[scan] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;                             // requester 0 first.
        end else if (found) begin
            ptr <= (int'(winner) == N - 1) ? '0 : winner + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ovc_status_table.sv
`timescale 1ns/1ps
`default_nettype none

// busy/free state of every output vc of the port.
module ovc_status_table (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      alloc_valid,      // a vc was granted.
    input  wire noc_pkg::ovc_idx_t   alloc_idx,
    input  wire                      release_valid,    // tail flit left.
    input  wire noc_pkg::ovc_idx_t   release_ovc,
    output noc_pkg::ovc_mask_t       free_mask
);

    noc_pkg::ovc_mask_t busy;
    noc_pkg::ovc_mask_t alloc_onehot;
    noc_pkg::ovc_mask_t release_onehot;
    noc_pkg::ovc_mask_t busy_nxt;

    ////////////////////////////////////////////////////////////
    // update.
    ////////////////////////////////////////////////////////////
    assign alloc_onehot   = alloc_valid   ? (noc_pkg::ovc_mask_t'(1) << alloc_idx)   : '0;
    assign release_onehot = release_valid ? (noc_pkg::ovc_mask_t'(1) << release_ovc) : '0;

    // release and allocate hit different vcs, so the order is free.
    assign busy_nxt = (busy & ~release_onehot) | alloc_onehot;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;                                // all vcs free.
        end else begin
            busy <= busy_nxt;
        end
    end

    assign free_mask = ~busy;

endmodule

`default_nettype wire

//--- rtl/vc_priority_based_dest_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

// destination port to preferred vc mask.
module vc_priority_based_dest_port #(
    parameter int P = `NOC_P,                  // router ports.
    parameter int V = `NOC_V                   // vcs per port.
) (
    input  wire noc_pkg::dest_t  dest_port,
    output noc_pkg::ovc_mask_t   vc_pririty
);

    localparam int P_1    = P - 1;             // destinations seen by one output.
    localparam int OFFSET = V / P_1;           // shift when vcs outnumber ports.

    logic [V-1:0] vc_pririty_init;

    generate
        if (P_1 == V) begin : g_direct
            // one destination per vc.
            assign vc_pririty_init = dest_port;
        end else if (P_1 > V) begin : g_fold
            // several destinations share one vc.
            for (genvar i = 0; i < V; i++) begin : g_bit
                localparam int LO = (i * P_1) / V;
                localparam int HI = ((i + 1) * P_1) / V - 1;
                assign vc_pririty_init[i] = |dest_port[HI:LO];
            end
        end else begin : g_spread
            // fewer destinations than vcs, place them above the offset.
            always_comb begin
                vc_pririty_init = '0;
                for (int j = 0; j < P_1; j++) begin
                    vc_pririty_init[j + OFFSET] = dest_port[j];
                end
            end
        end
    endgenerate

    // no destination bit set, fall back to vc 0.
    assign vc_pririty = (vc_pririty_init == '0) ? {{(V-1){1'b0}}, 1'b1} : vc_pririty_init;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, and judge by its output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module ovc_alloc_tb -Mdir obj_dir -o ovc_alloc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/ovc_alloc_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- verilog.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/class_ovc_table.sv
rtl/vc_priority_based_dest_port.sv
rtl/ovc_request_port.sv
rtl/ovc_rr_arbiter.sv
rtl/ovc_status_table.sv
rtl/ovc_alloc_top.sv
bench/ovc_alloc_tb.sv
